//--- exec_config.svh
// execute stage configuration
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

`define XLEN            64
`define RD_WD           5
`define CSR_ADDR_WD     12
`define SRAM_ADDR_WD    32
`define SRAM_WMASK_WD   8
`define SRAM_DEPTH_LOG2 8    // model depth in doublewords

// alu op, 5 bits
`define ALU_ADD  5'd0
`define ALU_SUB  5'd1
`define ALU_SLL  5'd2
`define ALU_SRL  5'd3
`define ALU_SRA  5'd4
`define ALU_SLT  5'd5
`define ALU_SLTU 5'd6
`define ALU_XOR  5'd7
`define ALU_OR   5'd8
`define ALU_AND  5'd9
`define ALU_LUI  5'd10

// operand selects
`define SRC1_RS1  1'b0
`define SRC1_PC   1'b1
`define SRC2_RS2  2'd0
`define SRC2_IMM  2'd1
`define SRC2_FOUR 2'd2   // link address for jal/jalr
`define SRC2_CSR  2'd3

`define CSR_RW 3'd1
`define CSR_RS 3'd2
`define CSR_RC 3'd3

// low two bits give the access size
`define MEM_B  3'd0
`define MEM_H  3'd1
`define MEM_W  3'd2
`define MEM_D  3'd3
`define MEM_BU 3'd4
`define MEM_HU 3'd5
`define MEM_WU 3'd6

`endif

//--- exu.sv
// execute alu and csr logic
`timescale 1ns/1ps
`include "exec_config.svh"

module exu (
  input  logic [`XLEN-1:0] i_rs1data,
  input  logic [`XLEN-1:0] i_rs2data,
  input  logic [`XLEN-1:0] i_imm,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_csrrdata,
  input  logic             i_alu_src1_sel,
  input  logic [1:0]       i_alu_src2_sel,
  input  logic [4:0]       i_alu_op,
  input  logic             i_alu_word_cut,
  input  logic [2:0]       i_csr_op,
  output logic [`XLEN-1:0] o_alu_result,
  output logic [`XLEN-1:0] o_csr_result
);

  logic [`XLEN-1:0] src1;
  logic [`XLEN-1:0] src2;
  logic [`XLEN-1:0] shin;    // shift source
  logic [5:0]       shamt;
  logic [`XLEN-1:0] raw;

  assign src1 = (i_alu_src1_sel == `SRC1_PC) ? i_pc : i_rs1data;

  always_comb begin
    case (i_alu_src2_sel)
      `SRC2_RS2:  src2 = i_rs2data;
      `SRC2_IMM:  src2 = i_imm;
      `SRC2_FOUR: src2 = `XLEN'(4);
      default:    src2 = i_csrrdata;
    endcase
  end

  // word ops shift only the low 32 bits, by 5 bits at most
  assign shamt = i_alu_word_cut ? {1'b0, src2[4:0]} : src2[5:0];

  always_comb begin
    if (!i_alu_word_cut) begin
      shin = src1;
    end else if (i_alu_op == `ALU_SRA) begin
      shin = {{32{src1[31]}}, src1[31:0]};
    end else begin
      shin = {32'b0, src1[31:0]};
    end
  end

  always_comb begin
    case (i_alu_op)
      `ALU_ADD:  raw = src1 + src2;
      `ALU_SUB:  raw = src1 - src2;
      `ALU_SLL:  raw = shin << shamt;
      `ALU_SRL:  raw = shin >> shamt;
      `ALU_SRA:  raw = $signed(shin) >>> shamt;
      `ALU_SLT:  raw = `XLEN'($signed(src1) < $signed(src2));
      `ALU_SLTU: raw = `XLEN'(src1 < src2);
      `ALU_XOR:  raw = src1 ^ src2;
      `ALU_OR:   raw = src1 | src2;
      `ALU_AND:  raw = src1 & src2;
      `ALU_LUI:  raw = src2;
      default:   raw = '0;
    endcase
  end

  assign o_alu_result = i_alu_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  always_comb begin
    case (i_csr_op)
      `CSR_RW: o_csr_result = i_rs1data;
      `CSR_RS: o_csr_result = i_rs1data | i_csrrdata;
      `CSR_RC: o_csr_result = i_csrrdata & ~i_rs1data;
      default: o_csr_result = '0;
    endcase
  end

endmodule

//--- exec_pkg.sv
// execute stage types
`include "exec_config.svh"

package exec_pkg;

  // one memory doubleword, flat or by byte lane
  typedef union packed {
    logic [`XLEN-1:0]               dword;
    logic [`SRAM_WMASK_WD-1:0][7:0] lane;   // lane[i] is byte i
  } mem_word_u;

endpackage

//--- lsu_store.sv
// store mask and lane data
`timescale 1ns/1ps
`include "exec_config.svh"

module lsu_store
  import exec_pkg::*;
(
  input  logic [2:0]                i_mem_op,
  input  logic [2:0]                i_addr_low,
  input  logic [`XLEN-1:0]          i_wdata,
  output logic [`SRAM_WMASK_WD-1:0] o_wmask,
  output mem_word_u                 o_wdata
);

  logic [`SRAM_WMASK_WD-1:0] base_mask;   // mask at offset 0
  logic [2:0]                lane_mod;    // access size in bytes minus one

  always_comb begin
    case (i_mem_op)
      `MEM_B, `MEM_BU: begin
        base_mask = 8'h01;
        lane_mod  = 3'd0;
      end
      `MEM_H, `MEM_HU: begin
        base_mask = 8'h03;
        lane_mod  = 3'd1;
      end
      `MEM_W, `MEM_WU: begin
        base_mask = 8'h0f;
        lane_mod  = 3'd3;
      end
      default: begin
        base_mask = 8'hff;
        lane_mod  = 3'd7;
      end
    endcase
    // halves and words sit on their natural boundary
    assert (((i_addr_low & lane_mod) != 3'd0 && lane_mod != 3'd7) !== 1'b1)
      else $error("lsu_store: misaligned access, op %0d offset %0d", i_mem_op, i_addr_low);
  end

  assign o_wmask = base_mask << i_addr_low;

  // each lane repeats the source byte at its place inside the access
  always_comb begin
    for (int i = 0; i < `SRAM_WMASK_WD; i++) begin
      o_wdata.lane[i] = i_wdata[8*(i & int'(lane_mod)) +: 8];
    end
  end

endmodule

//--- data_sram.sv
// data memory model
`timescale 1ns/1ps
`include "exec_config.svh"

module data_sram
  import exec_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic [`SRAM_ADDR_WD-1:0]  i_addr,
  input  logic                      i_ren,
  input  logic                      i_wen,
  input  logic [`SRAM_WMASK_WD-1:0] i_wmask,
  input  mem_word_u                 i_wdata,
  output logic                      o_addr_ok,
  output logic                      o_data_ok,
  output mem_word_u                 o_rdata,
  output logic                      o_rdata_valid
);

  localparam int DEPTH = 2 ** `SRAM_DEPTH_LOG2;

  mem_word_u                   mem [DEPTH];
  logic [`SRAM_DEPTH_LOG2-1:0] index;

  assign index     = i_addr[`SRAM_DEPTH_LOG2+2:3];   // doubleword index
  assign o_addr_ok = i_ren;                          // reads never refused

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_data_ok     <= 1'b0;
      o_rdata_valid <= 1'b0;
    end else begin
      o_data_ok     <= i_wen && !o_data_ok;
      o_rdata_valid <= i_ren;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      o_rdata <= mem[index];
    end
  end

  // write lands on the edge closing the data_ok cycle
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (i_wen && o_data_ok) begin
      for (int b = 0; b < `SRAM_WMASK_WD; b++) begin
        if (i_wmask[b]) begin
          mem[index].dword[8*b +: 8] <= i_wdata.dword[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- ex_stage.sv
// execute pipeline stage
`timescale 1ns/1ps
`include "exec_config.svh"

module ex_stage
  import exec_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_ms_allowin,
  input  logic                      i_ds_valid,
  output logic                      o_es_allowin,
  // decoded instruction
  input  logic [`XLEN-1:0]          i_rs1data, i_rs2data, i_csrrdata, i_imm, i_pc,
  input  logic                      i_alu_src1_sel,
  input  logic [1:0]                i_alu_src2_sel,
  input  logic [4:0]                i_alu_op,
  input  logic                      i_alu_word_cut,
  input  logic [2:0]                i_csr_op,
  input  logic [`RD_WD-1:0]         i_rd,
  input  logic [`CSR_ADDR_WD-1:0]   i_csr,
  input  logic                      i_gpr_wen, i_csr_wen, i_mem_ren, i_mem_wen,
  input  logic [2:0]                i_mem_op,
  input  logic                      i_csr_inst, i_load_inst, i_ebreak, i_invalid_inst,
  // to memory stage
  output logic                      o_es_to_ms_valid,
  output logic [`RD_WD-1:0]         o_ms_rd,
  output logic [`CSR_ADDR_WD-1:0]   o_ms_csr,
  output logic                      o_ms_gpr_wen, o_ms_csr_wen, o_ms_mem_ren,
  output logic [2:0]                o_ms_mem_op,
  output logic                      o_ms_csr_inst,
  output logic [`XLEN-1:0]          o_ms_csrrdata, o_ms_alu_result, o_ms_csr_result,
  output logic                      o_ms_ebreak, o_ms_invalid,
  // back to decode
  output logic                      o_load_stall,
  output logic [`RD_WD-1:0]         o_byp_rd,
  output logic [`XLEN-1:0]          o_byp_gpr_data,
  output logic [`CSR_ADDR_WD-1:0]   o_byp_csr,
  output logic [`XLEN-1:0]          o_byp_csr_data,
  // data sram
  output logic [`SRAM_ADDR_WD-1:0]  o_sram_addr,
  output logic                      o_sram_ren,
  output logic                      o_sram_wen,
  output logic [`SRAM_WMASK_WD-1:0] o_sram_wmask,
  output mem_word_u                 o_sram_wdata,
  input  logic                      i_sram_addr_ok,
  input  logic                      i_sram_data_ok
);

  logic                    es_valid;
  logic                    ready_go;
  logic                    store_done;   // write landed while ms was blocked
  logic [`XLEN-1:0]        es_rs1data, es_rs2data, es_csrrdata, es_imm, es_pc;
  logic                    es_alu_src1_sel;
  logic [1:0]              es_alu_src2_sel;
  logic [4:0]              es_alu_op;
  logic                    es_alu_word_cut;
  logic [2:0]              es_csr_op;
  logic [`RD_WD-1:0]       es_rd;
  logic [`CSR_ADDR_WD-1:0] es_csr;
  logic                    es_gpr_wen, es_csr_wen, es_mem_ren, es_mem_wen;
  logic [2:0]              es_mem_op;
  logic                    es_csr_inst, es_load_inst, es_ebreak, es_invalid;
  logic [`XLEN-1:0]        es_alu_result;
  logic [`XLEN-1:0]        es_csr_result;

  // loads wait for addr_ok, stores for data_ok
  assign ready_go = es_mem_ren ? i_sram_addr_ok
                  : es_mem_wen ? (i_sram_data_ok || store_done)
                  : 1'b1;
  assign o_es_allowin     = !es_valid || (ready_go && i_ms_allowin);
  assign o_es_to_ms_valid = es_valid && ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || o_es_allowin) begin
      store_done <= 1'b0;
    end else if (es_valid && es_mem_wen && i_sram_data_ok) begin
      store_done <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_valid && o_es_allowin) begin
      es_rs1data      <= i_rs1data;
      es_rs2data      <= i_rs2data;
      es_csrrdata     <= i_csrrdata;
      es_imm          <= i_imm;
      es_pc           <= i_pc;
      es_alu_src1_sel <= i_alu_src1_sel;
      es_alu_src2_sel <= i_alu_src2_sel;
      es_alu_op       <= i_alu_op;
      es_alu_word_cut <= i_alu_word_cut;
      es_csr_op       <= i_csr_op;
      es_rd           <= i_rd;
      es_csr          <= i_csr;
      es_gpr_wen      <= i_gpr_wen;
      es_csr_wen      <= i_csr_wen;
      es_mem_ren      <= i_mem_ren;
      es_mem_wen      <= i_mem_wen;
      es_mem_op       <= i_mem_op;
      es_csr_inst     <= i_csr_inst;
      es_load_inst    <= i_load_inst;
      es_ebreak       <= i_ebreak;
      es_invalid      <= i_invalid_inst;
    end
  end

  exu u_exu (
    .i_rs1data      (es_rs1data),
    .i_rs2data      (es_rs2data),
    .i_imm          (es_imm),
    .i_pc           (es_pc),
    .i_csrrdata     (es_csrrdata),
    .i_alu_src1_sel (es_alu_src1_sel),
    .i_alu_src2_sel (es_alu_src2_sel),
    .i_alu_op       (es_alu_op),
    .i_alu_word_cut (es_alu_word_cut),
    .i_csr_op       (es_csr_op),
    .o_alu_result   (es_alu_result),
    .o_csr_result   (es_csr_result)
  );

  lsu_store u_lsu_store (
    .i_mem_op   (es_mem_op),
    .i_addr_low (es_alu_result[2:0]),   // rs1 + imm
    .i_wdata    (es_rs2data),
    .o_wmask    (o_sram_wmask),
    .o_wdata    (o_sram_wdata)
  );

  assign o_sram_addr = es_alu_result[`SRAM_ADDR_WD-1:0];
  assign o_sram_ren  = es_valid && es_mem_ren && i_ms_allowin;
  assign o_sram_wen  = es_valid && es_mem_wen && !store_done;

  assign o_ms_rd         = es_rd;
  assign o_ms_csr        = es_csr;
  assign o_ms_gpr_wen    = es_gpr_wen;
  assign o_ms_csr_wen    = es_csr_wen;
  assign o_ms_mem_ren    = es_mem_ren;
  assign o_ms_mem_op     = es_mem_op;
  assign o_ms_csr_inst   = es_csr_inst;
  assign o_ms_csrrdata   = es_csrrdata;
  assign o_ms_alu_result = es_alu_result;
  assign o_ms_csr_result = es_csr_result;
  assign o_ms_ebreak     = es_ebreak;
  assign o_ms_invalid    = es_invalid;

  assign o_load_stall   = es_valid && es_load_inst;
  assign o_byp_rd       = (es_valid && es_gpr_wen) ? es_rd : '0;
  assign o_byp_gpr_data = (es_valid && es_gpr_wen) ? es_alu_result : '0;
  assign o_byp_csr      = (es_valid && es_csr_wen) ? es_csr : '0;
  assign o_byp_csr_data = (es_valid && es_csr_wen) ? es_csr_result : '0;

  a_ren_wen_excl: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_sram_ren && o_sram_wen));

  // a blocked result holds until ms takes it
  a_hold_blocked: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_es_to_ms_valid && !i_ms_allowin) |=> (o_es_to_ms_valid
      && $stable(o_ms_alu_result) && $stable(o_ms_csr_result) && $stable(o_ms_rd)));

endmodule

//--- ex_top.sv
// execute stage with data memory
`timescale 1ns/1ps
`include "exec_config.svh"

module ex_top
  import exec_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_ms_allowin,
  input  logic                    i_ds_valid,
  output logic                    o_es_allowin,
  input  logic [`XLEN-1:0]        i_rs1data, i_rs2data, i_csrrdata, i_imm, i_pc,
  input  logic                    i_alu_src1_sel,
  input  logic [1:0]              i_alu_src2_sel,
  input  logic [4:0]              i_alu_op,
  input  logic                    i_alu_word_cut,
  input  logic [2:0]              i_csr_op,
  input  logic [`RD_WD-1:0]       i_rd,
  input  logic [`CSR_ADDR_WD-1:0] i_csr,
  input  logic                    i_gpr_wen, i_csr_wen, i_mem_ren, i_mem_wen,
  input  logic [2:0]              i_mem_op,
  input  logic                    i_csr_inst, i_load_inst, i_ebreak, i_invalid_inst,
  output logic                    o_es_to_ms_valid,
  output logic [`RD_WD-1:0]       o_ms_rd,
  output logic [`CSR_ADDR_WD-1:0] o_ms_csr,
  output logic                    o_ms_gpr_wen, o_ms_csr_wen, o_ms_mem_ren,
  output logic [2:0]              o_ms_mem_op,
  output logic                    o_ms_csr_inst,
  output logic [`XLEN-1:0]        o_ms_csrrdata, o_ms_alu_result, o_ms_csr_result,
  output logic                    o_ms_ebreak, o_ms_invalid,
  output logic                    o_load_stall,
  output logic [`RD_WD-1:0]       o_byp_rd,
  output logic [`XLEN-1:0]        o_byp_gpr_data,
  output logic [`CSR_ADDR_WD-1:0] o_byp_csr,
  output logic [`XLEN-1:0]        o_byp_csr_data,
  // raw load data, aligned later in ms
  output mem_word_u               o_rdata,
  output logic                    o_rdata_valid
);

  logic [`SRAM_ADDR_WD-1:0]  sram_addr;
  logic                      sram_ren;
  logic                      sram_wen;
  logic [`SRAM_WMASK_WD-1:0] sram_wmask;
  mem_word_u                 sram_wdata;
  logic                      sram_addr_ok;
  logic                      sram_data_ok;

  ex_stage u_ex_stage (
    .*,
    .o_sram_addr    (sram_addr),
    .o_sram_ren     (sram_ren),
    .o_sram_wen     (sram_wen),
    .o_sram_wmask   (sram_wmask),
    .o_sram_wdata   (sram_wdata),
    .i_sram_addr_ok (sram_addr_ok),
    .i_sram_data_ok (sram_data_ok)
  );

  data_sram u_data_sram (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_addr        (sram_addr),
    .i_ren         (sram_ren),
    .i_wen         (sram_wen),
    .i_wmask       (sram_wmask),
    .i_wdata       (sram_wdata),
    .o_addr_ok     (sram_addr_ok),
    .o_data_ok     (sram_data_ok),
    .o_rdata       (o_rdata),
    .o_rdata_valid (o_rdata_valid)
  );

endmodule

//--- tb_ex_vectors.svh
// execute stage test vectors
`ifndef TB_EX_VECTORS_SVH
`define TB_EX_VECTORS_SVH

typedef struct packed {
  logic [4:0]       alu_op;
  logic             src1_sel;
  logic [1:0]       src2_sel;
  logic             word_cut;
  logic [2:0]       csr_op;
  logic             gpr_wen;
  logic             csr_wen;
  logic             mem_ren;
  logic             mem_wen;
  logic [2:0]       mem_op;
  logic [`XLEN-1:0] rs1;
  logic [`XLEN-1:0] rs2;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] csrr;
  logic [3:0]       hold;        // cycles with ms allowin low
  logic [`XLEN-1:0] exp_alu;
  logic [`XLEN-1:0] exp_csr;
  logic [7:0]       exp_wmask;
  mem_word_u        exp_wdata;
  mem_word_u        exp_rdata;
} vec_t;

localparam int NROWS = 49;

vec_t      vec [NROWS];
mem_word_u shadow [256];   // expected memory image, one entry per doubleword

function automatic vec_t random_row();
  vec_t v;
  v = '0;
  v.rs1  = rand64();
  v.rs2  = rand64();
  v.imm  = rand64();
  v.pc   = rand64();
  v.csrr = rand64();
  return v;
endfunction

// rv64 integer semantics, w ops work on the low word
function automatic logic [`XLEN-1:0] model_alu(input vec_t v);
  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [31:0]      w;
  a = v.src1_sel ? v.pc : v.rs1;
  case (v.src2_sel)
    `SRC2_RS2:  b = v.rs2;
    `SRC2_IMM:  b = v.imm;
    `SRC2_FOUR: b = 64'd4;
    default:    b = v.csrr;
  endcase
  if (v.word_cut) begin
    case (v.alu_op)
      `ALU_SUB: w = a[31:0] - b[31:0];
      `ALU_SLL: w = a[31:0] << b[4:0];
      `ALU_SRL: w = a[31:0] >> b[4:0];
      `ALU_SRA: w = $signed(a[31:0]) >>> b[4:0];
      default:  w = a[31:0] + b[31:0];
    endcase
    return {{32{w[31]}}, w};
  end
  case (v.alu_op)
    `ALU_ADD:  return a + b;
    `ALU_SUB:  return a - b;
    `ALU_SLL:  return a << b[5:0];
    `ALU_SRL:  return a >> b[5:0];
    `ALU_SRA:  return $signed(a) >>> b[5:0];
    `ALU_SLT:  return {63'b0, $signed(a) < $signed(b)};
    `ALU_SLTU: return {63'b0, a < b};
    `ALU_XOR:  return a ^ b;
    `ALU_OR:   return a | b;
    `ALU_AND:  return a & b;
    default:   return b;   // lui passes the immediate
  endcase
endfunction

function automatic logic [`XLEN-1:0] model_csr(input vec_t v);
  case (v.csr_op)
    `CSR_RW: return v.rs1;
    `CSR_RS: return v.rs1 | v.csrr;
    default: return v.csrr & ~v.rs1;
  endcase
endfunction

// store lanes repeat the source value across the doubleword
function automatic vec_t add_store_expect(input vec_t v);
  int         nbytes;
  logic [2:0] off;
  logic [7:0] idx;
  nbytes = 1 << v.mem_op[1:0];
  off    = v.exp_alu[2:0];
  idx    = v.exp_alu[10:3];
  v.exp_wmask = 8'((1 << nbytes) - 1) << off;
  for (int i = 0; i < 8; i++) begin
    v.exp_wdata.lane[i] = v.rs2[8*(i % nbytes) +: 8];
    if (v.exp_wmask[i]) begin
      shadow[idx].lane[i] = v.rs2[8*(i % nbytes) +: 8];
    end
  end
  return v;
endfunction

task automatic fill_vectors();
  int          n;
  logic [31:0] r;
  n = 0;
  lcg_state = 32'd84068;
  for (int i = 0; i < 256; i++) begin
    shadow[i] = '0;
  end
  for (int k = 0; k < 24; k++) begin
    r = next_rand();
    vec[n] = random_row();
    vec[n].alu_op   = 5'(r[31:24] % 8'd11);
    vec[n].src1_sel = r[20];
    vec[n].src2_sel = r[22:21];
    vec[n].word_cut = r[23] && (vec[n].alu_op <= `ALU_SRA);   // only the w ops
    vec[n].gpr_wen  = 1'b1;
    vec[n].hold     = (k % 6 == 5) ? 4'd3 : 4'd0;
    vec[n].exp_alu  = model_alu(vec[n]);
    n++;
  end
  // csr ops, rd gets the old csr value
  for (int k = 0; k < 6; k++) begin
    vec[n] = random_row();
    vec[n].alu_op   = `ALU_LUI;
    vec[n].src2_sel = `SRC2_CSR;
    vec[n].csr_op   = 3'(k % 3 + 1);
    vec[n].csr_wen  = (k % 2 == 0);
    vec[n].gpr_wen  = (k != 4);
    vec[n].exp_alu  = model_alu(vec[n]);
    vec[n].exp_csr  = model_csr(vec[n]);
    n++;
  end
  for (int w = 0; w < 4; w++) begin
    for (int off = 0; off < 8; off += (1 << w)) begin
      vec[n] = random_row();
      vec[n].mem_wen  = 1'b1;
      vec[n].mem_op   = 3'(w);
      vec[n].src2_sel = `SRC2_IMM;
      vec[n].rs1      = 64'h100 + 64'(w * 8);
      vec[n].imm      = 64'(off);
      vec[n].hold     = (w == 3) ? 4'd2 : 4'd0;
      vec[n].exp_alu  = model_alu(vec[n]);
      vec[n] = add_store_expect(vec[n]);
      n++;
    end
  end
  // read back each stored doubleword
  for (int w = 0; w < 4; w++) begin
    vec[n] = random_row();
    vec[n].mem_ren   = 1'b1;
    vec[n].gpr_wen   = 1'b1;
    vec[n].mem_op    = `MEM_D;
    vec[n].src2_sel  = `SRC2_IMM;
    vec[n].rs1       = 64'h100 + 64'(w * 8);
    vec[n].imm       = 64'd0;
    vec[n].hold      = (w == 1) ? 4'd2 : 4'd0;
    vec[n].exp_alu   = model_alu(vec[n]);
    vec[n].exp_rdata = shadow[vec[n].exp_alu[10:3]];
    n++;
  end
endtask

`endif

//--- tb_ex_top.sv
// execute stage testbench
`timescale 1ns/1ps
`include "exec_config.svh"

module tb_ex_top
  import exec_pkg::*;
();

  localparam int TIMEOUT = 20;   // cycles per wait

  logic                    i_clk, i_reset, i_ms_allowin, i_ds_valid;
  logic                    o_es_allowin;
  logic [`XLEN-1:0]        i_rs1data, i_rs2data, i_csrrdata, i_imm, i_pc;
  logic                    i_alu_src1_sel;
  logic [1:0]              i_alu_src2_sel;
  logic [4:0]              i_alu_op;
  logic                    i_alu_word_cut;
  logic [2:0]              i_csr_op;
  logic [`RD_WD-1:0]       i_rd;
  logic [`CSR_ADDR_WD-1:0] i_csr;
  logic                    i_gpr_wen, i_csr_wen, i_mem_ren, i_mem_wen;
  logic [2:0]              i_mem_op;
  logic                    i_csr_inst, i_load_inst, i_ebreak, i_invalid_inst;
  logic                    o_es_to_ms_valid;
  logic [`RD_WD-1:0]       o_ms_rd;
  logic [`CSR_ADDR_WD-1:0] o_ms_csr;
  logic                    o_ms_gpr_wen, o_ms_csr_wen, o_ms_mem_ren;
  logic [2:0]              o_ms_mem_op;
  logic                    o_ms_csr_inst;
  logic [`XLEN-1:0]        o_ms_csrrdata, o_ms_alu_result, o_ms_csr_result;
  logic                    o_ms_ebreak, o_ms_invalid;
  logic                    o_load_stall;
  logic [`RD_WD-1:0]       o_byp_rd;
  logic [`XLEN-1:0]        o_byp_gpr_data;
  logic [`CSR_ADDR_WD-1:0] o_byp_csr;
  logic [`XLEN-1:0]        o_byp_csr_data;
  mem_word_u               o_rdata;
  logic                    o_rdata_valid;

  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  logic        timed_out;

  ex_top i_ex_top (.*);

  `include "tb_ex_vectors.svh"

  always #50 i_clk = ~i_clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [`XLEN-1:0] rand64();
    logic [31:0] hi;
    hi = next_rand();
    return {hi, next_rand()};
  endfunction

  function automatic string row_kind(input vec_t v);
    if (v.mem_wen) return "store";
    if (v.mem_ren) return "load";
    if (v.csr_op != 3'd0) return "csr";
    return "alu";
  endfunction

  task automatic check_word(input logic [`XLEN-1:0] got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(input logic [`SRAM_WMASK_WD-1:0] got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_mem(input mem_word_u got, exp, input string what);
    checks++;
    if (got.dword !== exp.dword) begin
      errors++;
      $display("Fail %0t: %s, got %h expected %h", $time, what, got.dword, exp.dword);
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  // one instruction through the stage from 1 ns after a rising edge
  task automatic run_row(input int t);
    vec_t v;
    int   wait_n;
    logic saw_data_ok;
    v = vec[t];
    saw_data_ok    = 1'b0;
    i_ds_valid     = 1'b1;
    i_ms_allowin   = (v.hold == 4'd0);
    i_rs1data      = v.rs1;
    i_rs2data      = v.rs2;
    i_csrrdata     = v.csrr;
    i_imm          = v.imm;
    i_pc           = v.pc;
    i_alu_src1_sel = v.src1_sel;
    i_alu_src2_sel = v.src2_sel;
    i_alu_op       = v.alu_op;
    i_alu_word_cut = v.word_cut;
    i_csr_op       = v.csr_op;
    i_rd           = 5'(t + 1);
    i_csr          = 12'h300 + 12'(t);
    i_gpr_wen      = v.gpr_wen;
    i_csr_wen      = v.csr_wen;
    i_mem_ren      = v.mem_ren;
    i_mem_wen      = v.mem_wen;
    i_mem_op       = v.mem_op;
    i_csr_inst     = (v.csr_op != 3'd0);
    i_load_inst    = v.mem_ren;
    i_ebreak       = (t % 5 == 1);
    i_invalid_inst = (t % 5 == 3);
    wait_n = 0;
    @(negedge i_clk);
    while (!o_es_allowin && wait_n < TIMEOUT) begin
      @(negedge i_clk);
      wait_n++;
    end
    if (!o_es_allowin) begin
      $display("timeout: test %0d was never accepted by the stage", t);
      timed_out = 1'b1;
      return;
    end
    @(posedge i_clk);
    #1 i_ds_valid = 1'b0;
    @(negedge i_clk);
    if (v.mem_wen) begin
      check_flag(o_es_to_ms_valid, 1'b0, "store valid before data_ok");
      check_mask(i_ex_top.sram_wmask, v.exp_wmask, "store wmask");
      check_mem(i_ex_top.sram_wdata, v.exp_wdata, "store wdata");
    end
    check_flag(o_load_stall, v.mem_ren, "load stall");
    for (int h = 0; h < int'(v.hold); h++) begin
      if (h > 0) begin
        @(negedge i_clk);
      end
      saw_data_ok |= i_ex_top.sram_data_ok;
      check_flag(o_es_allowin, 1'b0, "allowin under back-pressure");
      check_flag(i_ex_top.sram_ren, 1'b0, "read under back-pressure");
      check_word(o_ms_alu_result, v.exp_alu, "held alu result");
    end
    if (v.hold != 4'd0) begin
      @(posedge i_clk);
      #1 i_ms_allowin = 1'b1;
      @(negedge i_clk);
    end
    wait_n = 0;
    saw_data_ok |= i_ex_top.sram_data_ok;
    while (!o_es_to_ms_valid && wait_n < TIMEOUT) begin
      @(negedge i_clk);
      saw_data_ok |= i_ex_top.sram_data_ok;
      wait_n++;
    end
    if (!o_es_to_ms_valid) begin
      $display("timeout: test %0d never reached the memory stage", t);
      timed_out = 1'b1;
      return;
    end
    check_word(o_ms_alu_result, v.exp_alu, "alu result");
    if (v.csr_op != 3'd0) begin
      check_word(o_ms_csr_result, v.exp_csr, "csr result");
    end
    check_word(`XLEN'(o_ms_rd), `XLEN'(i_rd), "ms rd");
    check_word(`XLEN'(o_ms_csr), `XLEN'(i_csr), "ms csr");
    check_word(`XLEN'(o_ms_mem_op), `XLEN'(v.mem_op), "ms mem op");
    check_word(o_ms_csrrdata, v.csrr, "ms csr read data");
    check_flag(o_ms_gpr_wen, v.gpr_wen, "ms gpr wen");
    check_flag(o_ms_csr_wen, v.csr_wen, "ms csr wen");
    check_flag(o_ms_mem_ren, v.mem_ren, "ms mem ren");
    check_flag(o_ms_csr_inst, v.csr_op != 3'd0, "ms csr inst");
    check_flag(o_ms_ebreak, i_ebreak, "ms ebreak");
    check_flag(o_ms_invalid, i_invalid_inst, "ms invalid");
    check_word(`XLEN'(o_byp_rd), v.gpr_wen ? `XLEN'(i_rd) : `XLEN'(0), "bypass rd");
    check_word(o_byp_gpr_data, v.gpr_wen ? v.exp_alu : `XLEN'(0), "bypass gpr data");
    check_word(`XLEN'(o_byp_csr), v.csr_wen ? `XLEN'(i_csr) : `XLEN'(0), "bypass csr");
    check_word(o_byp_csr_data, v.csr_wen ? v.exp_csr : `XLEN'(0), "bypass csr data");
    if (v.mem_wen) begin
      check_flag(saw_data_ok, 1'b1, "store valid without data_ok");
    end
    @(posedge i_clk);
    #1;
    if (v.mem_ren) begin
      wait_n = 0;
      @(negedge i_clk);
      while (!o_rdata_valid && wait_n < TIMEOUT) begin
        @(negedge i_clk);
        wait_n++;
      end
      if (!o_rdata_valid) begin
        $display("timeout: test %0d load data never returned", t);
        timed_out = 1'b1;
        return;
      end
      check_mem(o_rdata, v.exp_rdata, "load data");
      @(posedge i_clk);
      #1;
    end
  endtask

  initial begin
    i_clk          = 1'b0;
    i_reset        = 1'b1;
    i_ms_allowin   = 1'b1;
    i_ds_valid     = 1'b0;
    i_rs1data      = '0;
    i_rs2data      = '0;
    i_csrrdata     = '0;
    i_imm          = '0;
    i_pc           = '0;
    i_alu_src1_sel = 1'b0;
    i_alu_src2_sel = 2'd0;
    i_alu_op       = 5'd0;
    i_alu_word_cut = 1'b0;
    i_csr_op       = 3'd0;
    i_rd           = '0;
    i_csr          = '0;
    i_gpr_wen      = 1'b0;
    i_csr_wen      = 1'b0;
    i_mem_ren      = 1'b0;
    i_mem_wen      = 1'b0;
    i_mem_op       = 3'd0;
    i_csr_inst     = 1'b0;
    i_load_inst    = 1'b0;
    i_ebreak       = 1'b0;
    i_invalid_inst = 1'b0;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    fill_vectors();
    repeat (16) @(posedge i_clk);
    #1 i_reset = 1'b0;
    @(negedge i_clk);
    check_flag(o_es_to_ms_valid, 1'b0, "valid after reset");
    check_flag(o_rdata_valid, 1'b0, "rdata valid after reset");
    check_flag(o_load_stall, 1'b0, "load stall after reset");
    check_flag(i_ex_top.sram_ren, 1'b0, "sram ren after reset");
    check_flag(i_ex_top.sram_wen, 1'b0, "sram wen after reset");
    check_flag(i_ex_top.sram_data_ok, 1'b0, "data_ok after reset");
    check_word(`XLEN'(o_byp_rd), `XLEN'(0), "bypass rd after reset");
    check_word(o_byp_gpr_data, `XLEN'(0), "bypass data after reset");
    $display("test reset done, %0d errors so far", errors);
    @(posedge i_clk);
    #1;
    for (int t = 0; t < NROWS && !timed_out; t++) begin
      run_row(t);
      if (!timed_out) begin
        $display("test %0d %s done, %0d errors so far", t, row_kind(vec[t]), errors);
      end
    end
    $display("%0d tests, %0d checks, %0d errors", NROWS + 1, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+.
exu.sv
exec_pkg.sv
lsu_store.sv
data_sram.sv
ex_stage.sv
ex_top.sv
tb_ex_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ex_top -f src.f \
  && ./obj_dir/Vtb_ex_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qF '*** FAILED ***' sim.log && exit 1 || exit 0
